//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_cpu
FILELIST   := tb.f
FLAGS      := --binary --assert --timing -j 0
LINT_FLAGS := --lint-only --timing -Wall
OBJ_DIR    := obj_dir
SIM        := $(OBJ_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "=== PASS ==="

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- source/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
   input  logic                  clk,
   input  logic                  reset,
   input  cpu_bus_pkg::wb_dat_t  wb_dat_i,
   input  logic                  wb_ack,
   input  logic                  n,
   input  logic                  z,
   input  logic                  c,
   output logic                  wb_cyc,
   output logic                  wb_stb,
   output logic                  wb_we,
   output logic                  adr_sel,
   output logic                  s_sel,
   output cpu_isa_pkg::reg_adr_t w_adr,
   output cpu_isa_pkg::reg_adr_t r_adr,
   output cpu_isa_pkg::reg_adr_t s_adr,
   output logic                  rw_en,
   output logic                  ir_ld,
   output logic                  pc_inc,
   output logic                  pc_ld,
   output logic                  pc_sel,
   output cpu_isa_pkg::alu_op_t  alu_op,
   output cpu_isa_pkg::word_t    ir,
   output logic [7:0]            status
);

   import cpu_isa_pkg::*;

   cu_state_t state;
   cu_state_t next_state;
   logic      n_q, z_q, c_q;   // Present flags
   logic      flag_ld;
   logic      bus_gap;         // Idle cycle after every ack

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state   <= st_reset;
         bus_gap <= 1'b0;
      end else begin
         state   <= next_state;
         bus_gap <= wb_cyc & wb_ack;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         {n_q, z_q, c_q} <= 3'b000;
      end else if (flag_ld) begin
         {n_q, z_q, c_q} <= {n, z, c};
      end
   end

   always_ff @(posedge clk) begin
      if (ir_ld) begin
         ir <= wb_dat_i;      // Only asserted on the fetch ack
      end
   end

   // Control word and next state
   always_comb begin
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      adr_sel    = 1'b0;
      s_sel      = 1'b0;
      w_adr      = 3'b000;
      r_adr      = 3'b000;
      s_adr      = 3'b000;
      rw_en      = 1'b0;
      ir_ld      = 1'b0;
      pc_inc     = 1'b0;
      pc_ld      = 1'b0;
      pc_sel     = 1'b0;
      alu_op     = alu_pass;
      flag_ld    = 1'b0;
      status     = 8'hF0;
      next_state = state;

      case (state)
         st_reset: begin
            status     = 8'hFF;
            next_state = st_fetch;
         end
         st_fetch: begin
            status = 8'h80;
            if (!bus_gap) begin
               wb_cyc = 1'b1;
               wb_stb = 1'b1;
               if (wb_ack) begin
                  ir_ld      = 1'b1;
                  pc_inc     = 1'b1;
                  next_state = st_decode;
               end
            end
         end
         st_decode: begin
            status = 8'hC0;
            case (ir[15:9])
               op_add:  next_state = st_add;
               op_sub:  next_state = st_sub;
               op_cmp:  next_state = st_cmp;
               op_mov:  next_state = st_mov;
               op_shl:  next_state = st_shl;
               op_shr:  next_state = st_shr;
               op_inc:  next_state = st_inc;
               op_dec:  next_state = st_dec;
               op_ld:   next_state = st_ld;
               op_sto:  next_state = st_sto;
               op_ldi:  next_state = st_ldi;
               op_halt: next_state = st_halt;
               op_je:   next_state = st_je;
               op_jne:  next_state = st_jne;
               op_jc:   next_state = st_jc;
               op_jmp:  next_state = st_jmp;
               default: next_state = st_illegal_op;
            endcase
         end
         st_add, st_sub: begin   // R[8:6] <- R[5:3] op R[2:0]
            w_adr      = ir[8:6];
            r_adr      = ir[5:3];
            s_adr      = ir[2:0];
            rw_en      = 1'b1;
            alu_op     = (state == st_add) ? alu_add : alu_sub;
            flag_ld    = 1'b1;
            status     = {n_q, z_q, c_q, (state == st_add) ? sc_add : sc_sub};
            next_state = st_fetch;
         end
         st_cmp: begin
            r_adr      = ir[5:3];
            s_adr      = ir[2:0];
            alu_op     = alu_sub;   // Flags only, no write-back
            flag_ld    = 1'b1;
            status     = {n_q, z_q, c_q, sc_cmp};
            next_state = st_fetch;
         end
         st_mov: begin
            w_adr      = ir[8:6];
            s_adr      = ir[2:0];
            rw_en      = 1'b1;
            status     = {n_q, z_q, c_q, sc_mov};
            next_state = st_fetch;
         end
         st_shl, st_shr, st_inc, st_dec: begin
            w_adr   = ir[8:6];
            s_adr   = ir[2:0];
            rw_en   = 1'b1;
            flag_ld = 1'b1;
            case (state)
               st_shl: begin
                  alu_op = alu_shl;
                  status = {n_q, z_q, c_q, sc_shl};
               end
               st_shr: begin
                  alu_op = alu_shr;
                  status = {n_q, z_q, c_q, sc_shr};
               end
               st_inc: begin
                  alu_op = alu_inc;
                  status = {n_q, z_q, c_q, sc_inc};
               end
               default: begin
                  alu_op = alu_dec;
                  status = {n_q, z_q, c_q, sc_dec};
               end
            endcase
            next_state = st_fetch;
         end
         st_ld: begin   // R[8:6] <- M[R[2:0]]
            wb_cyc  = 1'b1;
            wb_stb  = 1'b1;
            adr_sel = 1'b1;
            s_sel   = 1'b1;
            r_adr   = ir[2:0];
            w_adr   = ir[8:6];
            status  = {n_q, z_q, c_q, sc_ld};
            if (wb_ack) begin
               rw_en      = 1'b1;
               next_state = st_fetch;
            end
         end
         st_sto: begin   // M[R[8:6]] <- R[2:0]
            wb_cyc  = 1'b1;
            wb_stb  = 1'b1;
            wb_we   = 1'b1;
            adr_sel = 1'b1;
            r_adr   = ir[8:6];
            s_adr   = ir[2:0];
            status  = {n_q, z_q, c_q, sc_sto};
            if (wb_ack) begin
               next_state = st_fetch;
            end
         end
         st_ldi: begin   // Immediate word follows the instruction
            wb_cyc = 1'b1;
            wb_stb = 1'b1;
            s_sel  = 1'b1;
            w_adr  = ir[8:6];
            status = {n_q, z_q, c_q, sc_ldi};
            if (wb_ack) begin
               rw_en      = 1'b1;
               pc_inc     = 1'b1;
               next_state = st_fetch;
            end
         end
         st_je: begin
            pc_ld      = z_q;
            status     = {n_q, z_q, c_q, sc_je};
            next_state = st_fetch;
         end
         st_jne: begin
            pc_ld      = ~z_q;
            status     = {n_q, z_q, c_q, sc_jne};
            next_state = st_fetch;
         end
         st_jc: begin
            pc_ld      = c_q;
            status     = {n_q, z_q, c_q, sc_jc};
            next_state = st_fetch;
         end
         st_jmp: begin
            s_adr      = ir[2:0];   // Target register
            pc_ld      = 1'b1;
            pc_sel     = 1'b1;
            status     = {n_q, z_q, c_q, sc_jmp};
            next_state = st_fetch;
         end
         st_halt: begin
            status = {n_q, z_q, c_q, sc_halt};
         end
         default: begin   // Illegal opcode trap, held until reset
            status     = 8'hF0;
            next_state = st_illegal_op;
         end
      endcase
   end

endmodule

`default_nettype wire

//--- source/cpu_bus_pkg.sv
`default_nettype none

package cpu_bus_pkg;

   // Word addressed Wishbone bus
   typedef logic [15:0] wb_adr_t;
   typedef logic [15:0] wb_dat_t;

   // First fetch address
   localparam wb_adr_t reset_vector = 16'h0000;

endpackage

`default_nettype wire

//--- source/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
   input  logic                 clk,
   input  logic                 reset,
   input  cpu_bus_pkg::wb_dat_t wb_dat_i,
   input  logic                 wb_ack,
   output logic                 wb_cyc,
   output logic                 wb_stb,
   output logic                 wb_we,
   output cpu_bus_pkg::wb_adr_t wb_adr,
   output cpu_bus_pkg::wb_dat_t wb_dat_o,
   output logic [7:0]           status
);

   import cpu_isa_pkg::*;
   import cpu_bus_pkg::*;

   // Control word
   logic     adr_sel, s_sel;
   reg_adr_t w_adr, r_adr, s_adr;
   logic     rw_en, ir_ld;
   logic     pc_inc, pc_ld, pc_sel;
   alu_op_t  alu_op;

   word_t    ir;
   word_t    jump_target;
   wb_adr_t  pc;
   logic     n, z, c;   // ALU flags before capture

   control_unit u_control (
      .clk      (clk),
      .reset    (reset),
      .wb_dat_i (wb_dat_i),
      .wb_ack   (wb_ack),
      .n        (n),
      .z        (z),
      .c        (c),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .adr_sel  (adr_sel),
      .s_sel    (s_sel),
      .w_adr    (w_adr),
      .r_adr    (r_adr),
      .s_adr    (s_adr),
      .rw_en    (rw_en),
      .ir_ld    (ir_ld),
      .pc_inc   (pc_inc),
      .pc_ld    (pc_ld),
      .pc_sel   (pc_sel),
      .alu_op   (alu_op),
      .ir       (ir),
      .status   (status)
   );

   program_counter u_pc (
      .clk         (clk),
      .reset       (reset),
      .pc_inc      (pc_inc),
      .pc_ld       (pc_ld),
      .pc_sel      (pc_sel),
      .ir          (ir),
      .jump_target (jump_target),
      .pc          (pc)
   );

   execution_unit u_exec (
      .clk         (clk),
      .reset       (reset),
      .w_adr       (w_adr),
      .r_adr       (r_adr),
      .s_adr       (s_adr),
      .rw_en       (rw_en),
      .s_sel       (s_sel),
      .adr_sel     (adr_sel),
      .alu_op      (alu_op),
      .pc          (pc),
      .wb_dat_i    (wb_dat_i),
      .n           (n),
      .z           (z),
      .c           (c),
      .jump_target (jump_target),
      .wb_adr      (wb_adr),
      .wb_dat_o    (wb_dat_o)
   );

endmodule

`default_nettype wire

//--- source/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

   typedef logic [15:0] word_t;     // Data or instruction word
   typedef logic [2:0]  reg_adr_t;  // Register file index

   // Opcode field, instruction bits 15:9
   typedef enum logic [6:0] {
      op_add  = 7'h70,
      op_sub  = 7'h71,
      op_cmp  = 7'h72,
      op_mov  = 7'h73,
      op_shl  = 7'h74,
      op_shr  = 7'h75,
      op_inc  = 7'h76,
      op_dec  = 7'h77,
      op_ld   = 7'h78,
      op_sto  = 7'h79,
      op_ldi  = 7'h7A,
      op_halt = 7'h7B,
      op_je   = 7'h7C,
      op_jne  = 7'h7D,
      op_jc   = 7'h7E,
      op_jmp  = 7'h7F
   } opcode_t;

   typedef enum logic [3:0] {
      alu_pass = 4'b0000,
      alu_inc  = 4'b0010,
      alu_dec  = 4'b0011,
      alu_add  = 4'b0100,
      alu_sub  = 4'b0101,
      alu_shr  = 4'b0110,
      alu_shl  = 4'b0111
   } alu_op_t;

   // Execute states follow the decode, one per opcode
   typedef enum logic [4:0] {
      st_reset      = 5'd0,
      st_fetch      = 5'd1,
      st_decode     = 5'd2,
      st_add        = 5'd3,
      st_sub, st_cmp, st_mov, st_inc, st_dec, st_shl, st_shr,
      st_ld, st_sto, st_ldi, st_je, st_jne, st_jc, st_jmp,
      st_halt       = 5'd18,
      st_illegal_op = 5'd31
   } cu_state_t;

   // Low status bits shown while executing
   localparam logic [4:0] sc_add  = 5'b00000;
   localparam logic [4:0] sc_sub  = 5'b00001;
   localparam logic [4:0] sc_cmp  = 5'b00010;
   localparam logic [4:0] sc_mov  = 5'b00011;
   localparam logic [4:0] sc_shl  = 5'b00100;
   localparam logic [4:0] sc_shr  = 5'b00101;
   localparam logic [4:0] sc_inc  = 5'b00110;
   localparam logic [4:0] sc_dec  = 5'b00111;
   localparam logic [4:0] sc_ld   = 5'b01000;
   localparam logic [4:0] sc_sto  = 5'b01001;
   localparam logic [4:0] sc_ldi  = 5'b01010;
   localparam logic [4:0] sc_halt = 5'b01011;
   localparam logic [4:0] sc_je   = 5'b01100;
   localparam logic [4:0] sc_jne  = 5'b01101;
   localparam logic [4:0] sc_jc   = 5'b01110;
   localparam logic [4:0] sc_jmp  = 5'b01111;

endpackage

`default_nettype wire

//--- source/execution_unit.sv
`timescale 1ns/1ps
`default_nettype none

module execution_unit (
   input  logic                  clk,
   input  logic                  reset,
   input  cpu_isa_pkg::reg_adr_t w_adr,
   input  cpu_isa_pkg::reg_adr_t r_adr,
   input  cpu_isa_pkg::reg_adr_t s_adr,
   input  logic                  rw_en,
   input  logic                  s_sel,
   input  logic                  adr_sel,
   input  cpu_isa_pkg::alu_op_t  alu_op,
   input  cpu_bus_pkg::wb_adr_t  pc,
   input  cpu_bus_pkg::wb_dat_t  wb_dat_i,
   output logic                  n,
   output logic                  z,
   output logic                  c,
   output cpu_isa_pkg::word_t    jump_target,
   output cpu_bus_pkg::wb_adr_t  wb_adr,
   output cpu_bus_pkg::wb_dat_t  wb_dat_o
);

   import cpu_isa_pkg::*;

   word_t regs [8];
   word_t r_val;      // R[r_adr]
   word_t s_val;      // R[s_adr]
   word_t alu_y;
   logic  alu_c;
   word_t wr_data;

   assign r_val = regs[r_adr];
   assign s_val = regs[s_adr];

   // ALU, carry is the 17th bit or the bit shifted out
   always_comb begin
      alu_c = 1'b0;
      case (alu_op)
         alu_inc: begin
            {alu_c, alu_y} = {1'b0, s_val} + 17'd1;
         end
         alu_dec: begin
            {alu_c, alu_y} = {1'b0, s_val} - 17'd1;   // Borrow when zero
         end
         alu_add: begin
            {alu_c, alu_y} = {1'b0, r_val} + {1'b0, s_val};
         end
         alu_sub: begin
            {alu_c, alu_y} = {1'b0, r_val} - {1'b0, s_val};
         end
         alu_shr: begin
            alu_y = {1'b0, s_val[15:1]};
            alu_c = s_val[0];
         end
         alu_shl: begin
            alu_y = {s_val[14:0], 1'b0};
            alu_c = s_val[15];
         end
         default: begin
            alu_y = s_val;   // Pass for MOV
         end
      endcase
   end

   assign n = alu_y[15];
   assign z = (alu_y == 16'h0000);
   assign c = alu_c;

   // Write-back from ALU or bus
   assign wr_data = s_sel ? wb_dat_i : alu_y;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (rw_en) begin
         regs[w_adr] <= wr_data;
      end
   end

   assign wb_adr      = adr_sel ? r_val : pc;
   assign wb_dat_o    = s_val;   // Store data
   assign jump_target = s_val;

endmodule

`default_nettype wire

//--- source/program_counter.sv
`timescale 1ns/1ps
`default_nettype none

module program_counter (
   input  logic                clk,
   input  logic                reset,
   input  logic                pc_inc,
   input  logic                pc_ld,
   input  logic                pc_sel,
   input  cpu_isa_pkg::word_t  ir,
   input  cpu_isa_pkg::word_t  jump_target,
   output cpu_bus_pkg::wb_adr_t pc
);

   import cpu_bus_pkg::*;

   wb_adr_t offset;

   // Branch offset from ir[7:0], sign extended
   assign offset = {{8{ir[7]}}, ir[7:0]};

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pc <= reset_vector;
      end else if (pc_ld) begin
         // PC already points past the branch here
         pc <= pc_sel ? jump_target : pc + offset;
      end else if (pc_inc) begin
         pc <= pc + 16'd1;
      end
   end

endmodule

`default_nettype wire

//--- tb.f
source/cpu_isa_pkg.sv
source/cpu_bus_pkg.sv
source/program_counter.sv
source/execution_unit.sv
source/control_unit.sv
source/cpu_core.sv
tests/cpu_core_assert.sv
tests/tb_cpu.sv

//--- tests/cpu_core_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_assert (
   input wire logic                 clk,
   input wire logic                 reset,
   input wire logic                 wb_cyc,
   input wire logic                 wb_stb,
   input wire logic                 wb_we,
   input wire logic                 wb_ack,
   input wire cpu_bus_pkg::wb_adr_t wb_adr,
   input wire cpu_bus_pkg::wb_dat_t wb_dat_o,
   input wire logic [7:0]           status
);

   import cpu_isa_pkg::*;
   import cpu_bus_pkg::*;

   int fail_count = 0;

   stb_needs_cyc: assert property (@(posedge clk) disable iff (reset)
      wb_stb |-> wb_cyc)
      else begin
         fail_count++;
         $error("wb_stb high without wb_cyc");
      end

   // Request held stable until the slave acks
   req_stable: assert property (@(posedge clk) disable iff (reset)
      (wb_cyc && wb_stb && !wb_ack) |=>
         (wb_stb && $stable(wb_adr) && $stable(wb_we) && $stable(wb_dat_o)))
      else begin
         fail_count++;
         $error("Bus request changed before ack");
      end

   first_fetch: assert property (@(posedge clk) disable iff (reset)
      (status == 8'hFF) |=> (wb_cyc && wb_adr == reset_vector))
      else begin
         fail_count++;
         $error("First fetch not at the reset vector");
      end

   halt_holds: assert property (@(posedge clk) disable iff (reset)
      (status[4:0] == sc_halt) |=> (!wb_cyc && status[4:0] == sc_halt))
      else begin
         fail_count++;
         $error("Core left HALT or started a bus cycle");
      end

   illegal_holds: assert property (@(posedge clk) disable iff (reset)
      (status == 8'hF0) |=> (!wb_cyc && status == 8'hF0))
      else begin
         fail_count++;
         $error("Core left the illegal opcode trap");
      end

endmodule

bind cpu_core cpu_core_assert u_assert (.*);

`default_nettype wire

//--- tests/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

   import cpu_isa_pkg::*;
   import cpu_bus_pkg::*;

   localparam int clk_period      = 100;
   localparam int watchdog_cycles = 4000;

   logic    clk;
   logic    reset;
   wb_dat_t wb_dat_i;
   logic    wb_ack;
   logic    wb_cyc;
   logic    wb_stb;
   logic    wb_we;
   wb_adr_t wb_adr;
   wb_dat_t wb_dat_o;
   logic [7:0] status;

   word_t   mem [256];
   int      seed;
   int      wait_left;
   logic    first_access;
   wb_adr_t exp_adr [$];   // Expected stores, oldest first
   wb_dat_t exp_dat [$];

   cpu_core u_dut (
      .clk      (clk),
      .reset    (reset),
      .wb_dat_i (wb_dat_i),
      .wb_ack   (wb_ack),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_o (wb_dat_o),
      .status   (status)
   );

   initial begin
      clk = 1'b0;
      forever #(clk_period / 2) clk = ~clk;
   end

   task automatic report_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
      $display("FAIL %s got %h expected %h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic report_error(input string text);
      $display("%s", text);
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   // Register format R[8:6] R[5:3] R[2:0]
   function automatic word_t enc(opcode_t op, int d, int r, int s);
      enc = {op, d[2:0], r[2:0], s[2:0]};
   endfunction

   // Branch format with 8-bit signed offset
   function automatic word_t enc_br(opcode_t op, logic [7:0] off);
      enc_br = {op, 1'b0, off};
   endfunction

   task automatic expect_store(input wb_adr_t adr, input wb_dat_t dat);
      exp_adr.push_back(adr);
      exp_dat.push_back(dat);
   endtask

   task automatic fill_memory();
      for (int i = 0; i < 256; i++) begin
         mem[i] = {8'hA5, i[7:0]};   // Opcode 0x52, never legal
      end
   endtask

   task automatic load_program_a();
      word_t p [49];
      p[0]  = enc(op_ldi, 1, 0, 0);
      p[1]  = 16'h1234;
      p[2]  = enc(op_ldi, 2, 0, 0);
      p[3]  = 16'h0F0F;
      p[4]  = enc(op_ldi, 7, 0, 0);
      p[5]  = 16'h0080;   // Result pointer
      p[6]  = enc(op_add, 3, 1, 2);
      p[7]  = enc(op_sto, 7, 0, 3);
      p[8]  = enc(op_inc, 7, 0, 7);
      p[9]  = enc(op_sub, 3, 2, 1);
      p[10] = enc(op_sto, 7, 0, 3);
      p[11] = enc(op_inc, 7, 0, 7);
      p[12] = enc(op_mov, 4, 0, 1);
      p[13] = enc(op_shl, 5, 0, 4);
      p[14] = enc(op_sto, 7, 0, 5);
      p[15] = enc(op_inc, 7, 0, 7);
      p[16] = enc(op_shr, 5, 0, 2);
      p[17] = enc(op_sto, 7, 0, 5);
      p[18] = enc(op_inc, 7, 0, 7);
      p[19] = enc(op_dec, 6, 0, 0);
      p[20] = enc(op_sto, 7, 0, 6);
      p[21] = enc(op_inc, 7, 0, 7);
      p[22] = enc(op_sto, 7, 0, 4);
      p[23] = enc(op_inc, 7, 0, 7);
      p[24] = enc(op_cmp, 0, 1, 1);   // Z set, C clear
      p[25] = enc_br(op_je, 8'h01);   // Taken
      p[26] = enc(op_sto, 7, 0, 6);   // Skipped
      p[27] = enc_br(op_jne, 8'h01);  // Not taken
      p[28] = enc(op_sto, 7, 0, 2);
      p[29] = enc_br(op_jc, 8'h01);   // Not taken
      p[30] = enc(op_inc, 7, 0, 7);
      p[31] = enc(op_sto, 7, 0, 1);
      p[32] = enc(op_cmp, 0, 2, 1);   // Borrow, not zero
      p[33] = enc_br(op_jc, 8'h01);   // Taken
      p[34] = enc(op_sto, 7, 0, 6);
      p[35] = enc_br(op_jne, 8'h01);  // Taken
      p[36] = enc(op_sto, 7, 0, 6);
      p[37] = enc_br(op_je, 8'h01);   // Not taken
      p[38] = enc(op_inc, 7, 0, 7);
      p[39] = enc(op_ldi, 3, 0, 0);
      p[40] = 16'h0080;
      p[41] = enc(op_ld, 4, 0, 3);
      p[42] = enc(op_sto, 7, 0, 4);
      p[43] = enc(op_ldi, 5, 0, 0);
      p[44] = 16'h0030;
      p[45] = enc(op_jmp, 0, 0, 5);
      p[46] = enc(op_halt, 0, 0, 0);  // Reached by the backward branch
      p[47] = enc(op_sto, 7, 0, 6);   // Skipped
      p[48] = enc_br(op_jne, 8'hFD);  // Taken back to word 46
      fill_memory();
      for (int i = 0; i < 49; i++) begin
         mem[i] = p[i];
      end
      // Worked out by hand from the instruction rules
      expect_store(16'h0080, 16'h2143);   // ADD
      expect_store(16'h0081, 16'hFCDB);   // SUB
      expect_store(16'h0082, 16'h2468);   // SHL
      expect_store(16'h0083, 16'h0787);   // SHR
      expect_store(16'h0084, 16'hFFFF);   // DEC of zero
      expect_store(16'h0085, 16'h1234);   // MOV
      expect_store(16'h0086, 16'h0F0F);   // After JE, JNE
      expect_store(16'h0087, 16'h1234);   // After JC
      expect_store(16'h0088, 16'h2143);   // LD back
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      first_access = 1'b1;
      repeat (3) @(posedge clk);
      #1 reset = 1'b0;
      if (wb_cyc !== 1'b0) report_error("Bus cycle active right after reset");
      if (status !== 8'hFF) report_value("status", {8'h00, status}, 16'h00FF);
   endtask

   // Wishbone slave that acks after 0 to 3 wait cycles
   initial begin
      wb_ack   = 1'b0;
      wb_dat_i = '0;
      wait_left = 0;
      forever begin
         @(posedge clk);
         #1;
         if (reset || wb_ack) begin
            wb_ack    = 1'b0;
            wait_left = $unsigned($random(seed)) % 4;
         end else if (wb_cyc && wb_stb) begin
            if (wait_left > 0) begin
               wait_left--;
            end else begin
               if (first_access && wb_adr !== reset_vector) begin
                  report_value("wb_adr", wb_adr, reset_vector);
               end
               first_access = 1'b0;
               if (wb_adr[15:8] !== 8'h00) begin
                  report_error("Bus address outside the 256-word memory");
               end
               if (wb_we) begin
                  if (exp_adr.size() == 0) begin
                     report_error("Store beyond the end of the expected stores");
                  end
                  if (wb_adr !== exp_adr[0]) begin
                     report_value("wb_adr", wb_adr, exp_adr[0]);
                  end
                  if (wb_dat_o !== exp_dat[0]) begin
                     report_value("wb_dat_o", wb_dat_o, exp_dat[0]);
                  end
                  mem[wb_adr[7:0]] = wb_dat_o;
                  exp_adr.delete(0);
                  exp_dat.delete(0);
               end else begin
                  wb_dat_i = mem[wb_adr[7:0]];
               end
               wb_ack = 1'b1;
            end
         end
      end
   end

   initial begin
      #(watchdog_cycles * clk_period);
      report_error("Timeout, the programs did not finish in time");
   end

   // Stop at the first failed assertion of the bound checker
   initial begin
      wait (u_dut.u_assert.fail_count != 0);
      report_error("Assertion failed in the bound checker");
   end

   initial begin
      seed  = 16;
      reset = 1'b1;

      // Program A
      load_program_a();
      apply_reset();
      while (status[4:0] !== sc_halt) begin
         @(posedge clk);
         #1;
      end
      if (status !== 8'h0B) report_value("status", {8'h00, status}, 16'h000B);
      repeat (10) begin
         @(posedge clk);
         #1;
         if (wb_cyc !== 1'b0) report_error("Bus cycle started after HALT");
      end
      if (exp_adr.size() != 0) begin
         report_error("Program A halted before all expected stores");
      end

      // Program B is a single illegal opcode
      fill_memory();
      mem[0] = 16'h0000;
      apply_reset();
      while (status !== 8'hF0) begin
         @(posedge clk);
         #1;
      end
      repeat (10) begin
         @(posedge clk);
         #1;
         if (wb_cyc !== 1'b0) report_error("Bus cycle started after illegal opcode");
         if (status !== 8'hF0) report_value("status", {8'h00, status}, 16'h00F0);
      end

      if (u_dut.u_assert.fail_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire
